// ==== files.f ====
common/base_cfg_pkg.sv
common/base_video_pkg.sv
spi_io/spi_io_rx.sv
spi_io/spi_io_cmd.sv
video/video_osd_mix.sv
logic/pcm_dac.sv
logic/platform_base.sv
tests/platform_base_asserts.sv
tests/platform_base_tb.sv

// ==== Makefile ====
TOP = platform_base_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f files.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f files.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "ALL CHECKS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== tests/platform_base_tb.sv ====
`default_nettype none
`timescale 1ns/1ns

module platform_base_tb;

    import base_cfg_pkg::*;
    import base_video_pkg::*;

    localparam int SEED         = 63781;
    localparam int SCK_HALF     = 4;
    localparam int DL_BYTES     = 64;
    localparam int SPI_BYTES    = 90;
    localparam int VID_LINES    = 27;
    localparam int VID_PIXELS   = 70;
    localparam int VIDEO_CYCLES = 4 * (VID_LINES * (VID_PIXELS + 2) + 4);
    localparam int DAC_HOLD     = 200;
    localparam int DAC_CYCLES   = 4 * DAC_HOLD;
    localparam int CYCLE_LIMIT  = SPI_BYTES * 70 + VIDEO_CYCLES + DAC_CYCLES + 3000;

    logic        clk_sys;
    logic        arst_n;
    logic        spi_sck;
    logic        spi_di;
    logic        spi_ss_io_n;
    logic        spi_ss_data_n;
    logic        pxl_cen;
    game_pixel_t game_pixel;
    logic [15:0] snd_left;
    logic [15:0] snd_right;
    video_out_t  video;
    logic        osd_shown;
    cfg_word_t   status;
    cfg_word_t   joystick0;
    cfg_word_t   joystick1;
    rom_wr_t     rom_wr;
    logic        downloading;
    logic        snd_pwm_left;
    logic        snd_pwm_right;

    // Reference state
    pos_t        m_px;
    pos_t        m_ln;
    logic        m_hs_q;
    video_cfg_t  cur_cfg;
    video_out_t  exp_video;
    logic        exp_osd;
    logic        exp_valid;
    logic [15:0] m_acc_l;
    logic [15:0] m_acc_r;
    logic        m_pwm_l;
    logic        m_pwm_r;
    rom_wr_t     exp_wr;
    spi_byte_t   spi_buf [0:DL_BYTES-1];
    logic        dl_armed;
    int          dl_count;
    int          n_checks;
    int          n_errors;
    int          test_err0;
    int          cycle_cnt;
    int          asrt_fails;

    platform_base u_platform_base (
        .clk_sys_i       ( clk_sys       ),
        .arst_n_i        ( arst_n        ),
        .spi_sck_i       ( spi_sck       ),
        .spi_di_i        ( spi_di        ),
        .spi_ss_io_n_i   ( spi_ss_io_n   ),
        .spi_ss_data_n_i ( spi_ss_data_n ),
        .pxl_cen_i       ( pxl_cen       ),
        .game_pixel_i    ( game_pixel    ),
        .snd_left_i      ( snd_left      ),
        .snd_right_i     ( snd_right     ),
        .video_o         ( video         ),
        .osd_shown_o     ( osd_shown     ),
        .status_o        ( status        ),
        .joystick0_o     ( joystick0     ),
        .joystick1_o     ( joystick1     ),
        .rom_wr_o        ( rom_wr        ),
        .downloading_o   ( downloading   ),
        .snd_pwm_left_o  ( snd_pwm_left  ),
        .snd_pwm_right_o ( snd_pwm_right )
    );

    always #5 clk_sys = ~clk_sys;

    // Sigma-delta reference for both channels
    always @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            m_acc_l <= '0;
            m_acc_r <= '0;
            m_pwm_l <= 1'b0;
            m_pwm_r <= 1'b0;
        end else begin
            {m_pwm_l, m_acc_l} <= {1'b0, m_acc_l} + {1'b0, ~snd_left[15], snd_left[14:0]};
            {m_pwm_r, m_acc_r} <= {1'b0, m_acc_r} + {1'b0, ~snd_right[15], snd_right[14:0]};
        end
    end

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clk_sys);
    endtask

    task automatic check_word(input string name, input cfg_word_t got, input cfg_word_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_rom_wr(input rom_wr_t got, input rom_wr_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("error: rom_wr_o got %h expected %h", got, exp);
        end
    endtask

    task automatic check_video(input video_out_t got, input video_out_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("error: video_o got %h expected %h", got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic finish_test(input string name);
        $display("test %s done, %0d errors", name, n_errors - test_err0);
        test_err0 = n_errors;
    endtask

    // Mode 0 frame sent MSB first from spi_buf
    task automatic send_spi_frame(input logic data_sel, input int n_bytes);
        if (data_sel) begin
            spi_ss_data_n = 1'b0;
        end else begin
            spi_ss_io_n = 1'b0;
        end
        wait_cycles(6);
        for (int i = 0; i < n_bytes; i++) begin
            for (int b = 7; b >= 0; b--) begin
                spi_di = spi_buf[i][b];
                wait_cycles(SCK_HALF);
                spi_sck = 1'b1;
                wait_cycles(SCK_HALF);
                spi_sck = 1'b0;
            end
        end
        wait_cycles(6);
        if (data_sel) begin
            check_bit("downloading_o", downloading, 1'b1);
        end
        spi_ss_io_n   = 1'b1;
        spi_ss_data_n = 1'b1;
        wait_cycles(6);
    endtask

    task automatic send_word_cmd(input spi_byte_t cmd, input cfg_word_t w);
        spi_buf[0] = cmd;
        for (int i = 0; i < CFG_WORD_BYTES; i++) begin
            spi_buf[i+1] = w[8*i +: 8];
        end
        send_spi_frame(1'b0, 1 + CFG_WORD_BYTES);
    endtask

    task automatic send_video_cfg(input video_cfg_t cfg);
        spi_buf[0]      = CMD_VIDEO;
        spi_buf[1]      = 8'($urandom);
        spi_buf[1][1:0] = cfg;
        send_spi_frame(1'b0, 2);
    endtask

    // Checks the previous pixel, drives a new one and predicts its output
    task automatic video_step(input logic hs, input logic vs);
        game_pixel_t px;
        logic        cen;
        logic        in_win;
        if (exp_valid) begin
            check_video(video, exp_video);
            check_bit("osd_shown_o", osd_shown, exp_osd);
        end
        px.r       = 4'($urandom);
        px.g       = 4'($urandom);
        px.b       = 4'($urandom);
        px.hs      = hs;
        px.vs      = vs;
        cen        = ($urandom % 4) != 0;
        game_pixel = px;
        pxl_cen    = cen;
        in_win = (m_px >= OSD_X0) && (m_px <= OSD_X1) && (m_ln >= OSD_Y0) && (m_ln <= OSD_Y1);
        exp_osd     = cur_cfg.osd_en & in_win;
        exp_video.r = {px.r, px.r[3:2]};
        exp_video.g = {px.g, px.g[3:2]};
        exp_video.b = {px.b, px.b[3:2]};
        if (exp_osd) begin
            exp_video.r = exp_video.r >> 1;
            exp_video.g = exp_video.g >> 1;
            exp_video.b = (exp_video.b >> 1) + 6'h20;
        end
        if (cur_cfg.csync_en) begin
            exp_video.hsync = ~(hs ^ vs);
            exp_video.vsync = 1'b1;
        end else begin
            exp_video.hsync = hs;
            exp_video.vsync = vs;
        end
        // Position as the DUT will hold it after this pixel
        if (hs) begin
            m_px = '0;
        end else if (cen) begin
            m_px = m_px + 10'd1;
        end
        if (vs) begin
            m_ln = '0;
        end else if (hs && !m_hs_q) begin
            m_ln = m_ln + 10'd1;
        end
        m_hs_q    = hs;
        exp_valid = 1'b1;
        @(negedge clk_sys);
    endtask

    // Download write monitor
    always @(negedge clk_sys) begin
        if (arst_n && rom_wr.wr) begin
            if (!dl_armed || dl_count >= DL_BYTES) begin
                n_errors++;
                $display("write strobe seen outside the expected download bytes");
            end else begin
                exp_wr.addr = rom_addr_t'(dl_count);
                exp_wr.data = spi_buf[dl_count];
                exp_wr.wr   = 1'b1;
                check_rom_wr(rom_wr, exp_wr);
            end
            dl_count++;
        end
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < CYCLE_LIMIT) begin
            @(posedge clk_sys);
            cycle_cnt++;
        end
        $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        cfg_word_t w;
        cfg_word_t exp_status;
        void'($urandom(SEED));
        clk_sys       = 1'b0;
        arst_n        = 1'b0;
        spi_sck       = 1'b0;
        spi_di        = 1'b0;
        spi_ss_io_n   = 1'b1;
        spi_ss_data_n = 1'b1;
        pxl_cen       = 1'b0;
        game_pixel    = '0;
        snd_left      = '0;
        snd_right     = '0;
        cur_cfg       = '0;
        exp_video     = '0;
        exp_osd       = 1'b0;
        exp_valid     = 1'b0;
        m_px          = '0;
        m_ln          = '0;
        m_hs_q        = 1'b0;
        exp_wr        = '0;
        dl_armed      = 1'b0;
        dl_count      = 0;
        n_checks      = 0;
        n_errors      = 0;
        test_err0     = 0;

        wait_cycles(16);
        arst_n = 1'b1;
        @(negedge clk_sys);
        check_word("status_o", status, '0);
        check_word("joystick0_o", joystick0, '0);
        check_word("joystick1_o", joystick1, '0);
        check_rom_wr(rom_wr, '0);
        check_bit("downloading_o", downloading, 1'b0);
        check_bit("snd_pwm_left_o", snd_pwm_left, 1'b0);
        check_bit("snd_pwm_right_o", snd_pwm_right, 1'b0);
        check_video(video, '0);
        finish_test("reset");

        // Hold both syncs high between video runs so the counters stay cleared
        game_pixel.hs = 1'b1;
        game_pixel.vs = 1'b1;

        w = cfg_word_t'($urandom);
        exp_status = w;
        send_word_cmd(CMD_STATUS, w);
        check_word("status_o", status, w);
        w = cfg_word_t'($urandom);
        send_word_cmd(CMD_JOY0, w);
        check_word("joystick0_o", joystick0, w);
        w = cfg_word_t'($urandom);
        send_word_cmd(CMD_JOY1, w);
        check_word("joystick1_o", joystick1, w);
        spi_buf[0] = CMD_STATUS;
        spi_buf[1] = 8'($urandom);
        spi_buf[2] = 8'($urandom);
        send_spi_frame(1'b0, 3);
        check_word("status_o", status, exp_status);
        finish_test("config words");

        for (int i = 0; i < DL_BYTES; i++) begin
            spi_buf[i] = 8'($urandom);
        end
        dl_count = 0;
        dl_armed = 1'b1;
        send_spi_frame(1'b1, DL_BYTES);
        dl_armed = 1'b0;
        check_bit("downloading_o", downloading, 1'b0);
        n_checks++;
        if (dl_count != DL_BYTES) begin
            n_errors++;
            $display("download of %0d bytes gave %0d writes", DL_BYTES, dl_count);
        end
        finish_test("rom download");

        for (int combo = 0; combo < 4; combo++) begin
            cur_cfg = video_cfg_t'(combo[1:0]);
            send_video_cfg(cur_cfg);
            m_px      = '0;
            m_ln      = '0;
            m_hs_q    = 1'b1;
            exp_valid = 1'b0;
            for (int ln = 0; ln < VID_LINES; ln++) begin
                video_step(1'b1, ln == 0);
                video_step(1'b1, 1'b0);
                for (int p = 0; p < VID_PIXELS; p++) begin
                    video_step(1'b0, 1'b0);
                end
            end
            video_step(1'b1, 1'b1);
            check_video(video, exp_video);
            check_bit("osd_shown_o", osd_shown, exp_osd);
            exp_valid = 1'b0;
        end
        finish_test("video mix");

        for (int k = 0; k < 4; k++) begin
            snd_left  = 16'($urandom);
            snd_right = 16'($urandom);
            repeat (DAC_HOLD) begin
                @(negedge clk_sys);
                check_bit("snd_pwm_left_o", snd_pwm_left, m_pwm_l);
                check_bit("snd_pwm_right_o", snd_pwm_right, m_pwm_r);
            end
        end
        finish_test("audio dac");

        asrt_fails = u_platform_base.u_asserts.fail_wr_pulse
                   + u_platform_base.u_asserts.fail_wr_window
                   + u_platform_base.u_asserts.fail_vsync;
        if (asrt_fails != 0) begin
            n_errors += asrt_fails;
            $display("bound assertions failed %0d times", asrt_fails);
        end

        $display("checks %0d, errors %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/platform_base_asserts.sv ====
`default_nettype none
`timescale 1ns/1ns

module platform_base_asserts (
    input logic                  clk_sys_i,
    input logic                  arst_n_i,
    input base_cfg_pkg::rom_wr_t rom_wr_i,
    input logic                  downloading_i,
    input logic                  csync_en_i,
    input logic                  vsync_i
);

    // Failure tallies, one per property
    int fail_wr_pulse  = 0;
    int fail_wr_window = 0;
    int fail_vsync     = 0;

    // Write strobe is a single-cycle pulse
    wr_pulse_a: assert property (@(posedge clk_sys_i) disable iff (!arst_n_i)
        rom_wr_i.wr |=> !rom_wr_i.wr)
    else begin
        fail_wr_pulse++;
        $error("rom_wr_o.wr stayed high for more than one cycle");
    end

    // Writes only inside a download frame
    wr_window_a: assert property (@(posedge clk_sys_i) disable iff (!arst_n_i)
        rom_wr_i.wr |-> downloading_i)
    else begin
        fail_wr_window++;
        $error("rom_wr_o.wr is high while downloading_o is low");
    end

    // Output register lags the config by one cycle
    vsync_a: assert property (@(posedge clk_sys_i) disable iff (!arst_n_i)
        csync_en_i |=> vsync_i)
    else begin
        fail_vsync++;
        $error("vsync dropped while composite sync is on");
    end

endmodule

bind platform_base platform_base_asserts u_asserts (
    .clk_sys_i     ( clk_sys_i          ),
    .arst_n_i      ( arst_n_i           ),
    .rom_wr_i      ( rom_wr_o           ),
    .downloading_i ( downloading_o      ),
    .csync_en_i    ( video_cfg.csync_en ),
    .vsync_i       ( video_o.vsync      )
);

`default_nettype wire

// ==== logic/platform_base.sv ====
`default_nettype none
`timescale 1ns/1ns

module platform_base (
    input  logic                        clk_sys_i,
    input  logic                        arst_n_i,
    input  logic                        spi_sck_i,
    input  logic                        spi_di_i,
    input  logic                        spi_ss_io_n_i,
    input  logic                        spi_ss_data_n_i,
    input  logic                        pxl_cen_i,
    input  base_video_pkg::game_pixel_t game_pixel_i,
    input  logic [15:0]                 snd_left_i,
    input  logic [15:0]                 snd_right_i,
    output base_video_pkg::video_out_t  video_o,
    output logic                        osd_shown_o,
    output base_cfg_pkg::cfg_word_t     status_o,
    output base_cfg_pkg::cfg_word_t     joystick0_o,
    output base_cfg_pkg::cfg_word_t     joystick1_o,
    output base_cfg_pkg::rom_wr_t       rom_wr_o,
    output logic                        downloading_o,
    output logic                        snd_pwm_left_o,
    output logic                        snd_pwm_right_o
);

    import base_cfg_pkg::*;

    spi_byte_t  rx_byte;
    logic       rx_valid;
    logic       rx_data_chan;
    logic       rx_frame_start;
    logic       rx_data_active;
    video_cfg_t video_cfg;

    spi_io_rx u_spi_rx (
        .clk_sys_i       ( clk_sys_i       ),
        .arst_n_i        ( arst_n_i        ),
        .spi_sck_i       ( spi_sck_i       ),
        .spi_di_i        ( spi_di_i        ),
        .spi_ss_io_n_i   ( spi_ss_io_n_i   ),
        .spi_ss_data_n_i ( spi_ss_data_n_i ),
        .byte_o          ( rx_byte         ),
        .byte_valid_o    ( rx_valid        ),
        .data_chan_o     ( rx_data_chan    ),
        .frame_start_o   ( rx_frame_start  ),
        .data_active_o   ( rx_data_active  )
    );

    spi_io_cmd u_spi_cmd (
        .clk_sys_i       ( clk_sys_i       ),
        .arst_n_i        ( arst_n_i        ),
        .byte_i          ( rx_byte         ),
        .byte_valid_i    ( rx_valid        ),
        .data_chan_i     ( rx_data_chan    ),
        .frame_start_i   ( rx_frame_start  ),
        .data_active_i   ( rx_data_active  ),
        .status_o        ( status_o        ),
        .joystick0_o     ( joystick0_o     ),
        .joystick1_o     ( joystick1_o     ),
        .video_cfg_o     ( video_cfg       ),
        .rom_wr_o        ( rom_wr_o        ),
        .downloading_o   ( downloading_o   )
    );

    video_osd_mix u_video_mix (
        .clk_sys_i       ( clk_sys_i       ),
        .arst_n_i        ( arst_n_i        ),
        .pxl_cen_i       ( pxl_cen_i       ),
        .pixel_i         ( game_pixel_i    ),
        .video_cfg_i     ( video_cfg       ),
        .video_o         ( video_o         ),
        .osd_shown_o     ( osd_shown_o     )
    );

    // Stereo, signed samples from the game
    pcm_dac #(.SIGNED_SND(1'b1)) u_dac_left (
        .clk_sys_i       ( clk_sys_i       ),
        .arst_n_i        ( arst_n_i        ),
        .pcm_i           ( snd_left_i      ),
        .pwm_o           ( snd_pwm_left_o  )
    );

    pcm_dac #(.SIGNED_SND(1'b1)) u_dac_right (
        .clk_sys_i       ( clk_sys_i       ),
        .arst_n_i        ( arst_n_i        ),
        .pcm_i           ( snd_right_i     ),
        .pwm_o           ( snd_pwm_right_o )
    );

endmodule

`default_nettype wire

// ==== logic/pcm_dac.sv ====
`default_nettype none
`timescale 1ns/1ns

module pcm_dac #(
    parameter bit SIGNED_SND = 1'b0
) (
    input  logic        clk_sys_i,
    input  logic        arst_n_i,
    input  logic [15:0] pcm_i,
    output logic        pwm_o
);

    logic [15:0] pcm_ofs;
    logic [15:0] acc;
    logic [16:0] sum;

    // Signed samples become offset binary
    assign pcm_ofs = {pcm_i[15] ^ SIGNED_SND, pcm_i[14:0]};

    assign sum = {1'b0, acc} + {1'b0, pcm_ofs};

    // The carry out is the density-modulated bit
    always_ff @(posedge clk_sys_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            acc   <= '0;
            pwm_o <= 1'b0;
        end else begin
            acc   <= sum[15:0];
            pwm_o <= sum[16];
        end
    end

endmodule

`default_nettype wire

// ==== video/video_osd_mix.sv ====
`default_nettype none
`timescale 1ns/1ns

module video_osd_mix (
    input  logic                       clk_sys_i,
    input  logic                       arst_n_i,
    input  logic                       pxl_cen_i,
    input  base_video_pkg::game_pixel_t pixel_i,
    input  base_cfg_pkg::video_cfg_t   video_cfg_i,
    output base_video_pkg::video_out_t video_o,
    output logic                       osd_shown_o
);

    import base_video_pkg::*;

    pos_t       px_cnt;
    pos_t       ln_cnt;
    logic       hs_q;
    logic       hs_rise;
    logic       in_win;
    logic       osd_on;
    out_color_t r_w;
    out_color_t g_w;
    out_color_t b_w;
    out_color_t r_mix;
    out_color_t g_mix;
    out_color_t b_mix;

    // Top bits repeated below to fill the DAC range
    function automatic out_color_t widen(input game_color_t c);
        return {c, c[GAME_COLOR_W-1 -: (OUT_COLOR_W - GAME_COLOR_W)]};
    endfunction

    assign hs_rise = pixel_i.hs & ~hs_q;

    // Position counters
    always_ff @(posedge clk_sys_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            px_cnt <= '0;
            ln_cnt <= '0;
            hs_q   <= 1'b0;
        end else begin
            hs_q <= pixel_i.hs;
            if (pixel_i.hs) begin
                px_cnt <= '0;
            end else if (pxl_cen_i) begin
                px_cnt <= px_cnt + 1'b1;
            end
            if (pixel_i.vs) begin
                ln_cnt <= '0;
            end else if (hs_rise) begin
                ln_cnt <= ln_cnt + 1'b1;
            end
        end
    end

    always_comb begin
        in_win = (px_cnt >= OSD_X0) && (px_cnt <= OSD_X1) &&
                 (ln_cnt >= OSD_Y0) && (ln_cnt <= OSD_Y1);
        osd_on = video_cfg_i.osd_en & in_win;
        r_w    = widen(pixel_i.r);
        g_w    = widen(pixel_i.g);
        b_w    = widen(pixel_i.b);
        if (osd_on) begin
            // Dimmed game picture with a blue tint
            r_mix = r_w >> 1;
            g_mix = g_w >> 1;
            b_mix = (b_w >> 1) + 6'h20;
        end else begin
            r_mix = r_w;
            g_mix = g_w;
            b_mix = b_w;
        end
    end

    always_ff @(posedge clk_sys_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            video_o     <= '0;
            osd_shown_o <= 1'b0;
        end else begin
            video_o.r   <= r_mix;
            video_o.g   <= g_mix;
            video_o.b   <= b_mix;
            osd_shown_o <= osd_on;
            if (video_cfg_i.csync_en) begin
                // SCART cables want composite sync on HS and VS tied high
                video_o.hsync <= ~(pixel_i.hs ^ pixel_i.vs);
                video_o.vsync <= 1'b1;
            end else begin
                video_o.hsync <= pixel_i.hs;
                video_o.vsync <= pixel_i.vs;
            end
        end
    end

endmodule

`default_nettype wire

// ==== spi_io/spi_io_cmd.sv ====
`default_nettype none
`timescale 1ns/1ns

module spi_io_cmd (
    input  logic                     clk_sys_i,
    input  logic                     arst_n_i,
    input  base_cfg_pkg::spi_byte_t  byte_i,
    input  logic                     byte_valid_i,
    input  logic                     data_chan_i,
    input  logic                     frame_start_i,
    input  logic                     data_active_i,
    output base_cfg_pkg::cfg_word_t  status_o,
    output base_cfg_pkg::cfg_word_t  joystick0_o,
    output base_cfg_pkg::cfg_word_t  joystick1_o,
    output base_cfg_pkg::video_cfg_t video_cfg_o,
    output base_cfg_pkg::rom_wr_t    rom_wr_o,
    output logic                     downloading_o
);

    import base_cfg_pkg::*;

    typedef enum logic [1:0] {
        CMD,
        DATA,
        IGNORE
    } cmd_state_t;

    cmd_state_t state;
    spi_byte_t  cmd_q;
    logic [1:0] byte_cnt;
    logic [23:0] shadow_q;
    cfg_word_t  word_next;
    rom_addr_t  next_addr;
    logic       cfg_byte;
    logic       dl_byte;

    assign cfg_byte  = byte_valid_i & ~data_chan_i;
    assign dl_byte   = byte_valid_i & data_chan_i;

    // Completed word once the last data byte is in
    assign word_next = {byte_i, shadow_q};

    // Words come in LSB first so they shift in from the top
    always_ff @(posedge clk_sys_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            shadow_q <= '0;
        end else if (cfg_byte && state == DATA) begin
            shadow_q <= {byte_i, shadow_q[23:8]};
        end
    end

    always_ff @(posedge clk_sys_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state       <= CMD;
            cmd_q       <= '0;
            byte_cnt    <= '0;
            status_o    <= '0;
            joystick0_o <= '0;
            joystick1_o <= '0;
            video_cfg_o <= '0;
        end else if (frame_start_i) begin
            state    <= CMD;
            byte_cnt <= '0;
        end else if (cfg_byte) begin
            case (state)
                CMD: begin
                    cmd_q    <= byte_i;
                    byte_cnt <= '0;
                    case (byte_i)
                        CMD_JOY0, CMD_JOY1, CMD_STATUS, CMD_VIDEO: state <= DATA;
                        default: state <= IGNORE;
                    endcase
                end
                DATA: begin
                    byte_cnt <= byte_cnt + 2'd1;
                    if (cmd_q == CMD_VIDEO) begin
                        video_cfg_o <= video_cfg_t'(byte_i[1:0]);
                        state       <= IGNORE;
                    end else if (byte_cnt == 2'(CFG_WORD_BYTES - 1)) begin
                        case (cmd_q)
                            CMD_STATUS: status_o    <= word_next;
                            CMD_JOY0:   joystick0_o <= word_next;
                            CMD_JOY1:   joystick1_o <= word_next;
                            default:    ;
                        endcase
                        state <= IGNORE;
                    end
                end
                default: ;
            endcase
        end
    end

    // ROM download stream, one strobe per byte
    always_ff @(posedge clk_sys_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            next_addr     <= '0;
            rom_wr_o      <= '0;
            downloading_o <= 1'b0;
        end else begin
            downloading_o <= data_active_i;
            rom_wr_o.wr   <= 1'b0;
            if (frame_start_i) begin
                next_addr <= '0;
            end else if (dl_byte) begin
                rom_wr_o.addr <= next_addr;
                rom_wr_o.data <= byte_i;
                rom_wr_o.wr   <= 1'b1;
                next_addr     <= next_addr + 25'd1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== spi_io/spi_io_rx.sv ====
`default_nettype none
`timescale 1ns/1ns

module spi_io_rx (
    input  logic                  clk_sys_i,
    input  logic                  arst_n_i,
    input  logic                  spi_sck_i,
    input  logic                  spi_di_i,
    input  logic                  spi_ss_io_n_i,
    input  logic                  spi_ss_data_n_i,
    output base_cfg_pkg::spi_byte_t byte_o,
    output logic                  byte_valid_o,
    output logic                  data_chan_o,
    output logic                  frame_start_o,
    output logic                  data_active_o
);

    // Two-flop synchronisers, index 1 is the safe output
    logic [1:0] sck_sync;
    logic [1:0] di_sync;
    logic [1:0] ss_io_sync;
    logic [1:0] ss_data_sync;

    // Previous synchronised values for edge detection
    logic sck_q;
    logic ss_io_q;
    logic ss_data_q;

    logic sck_rise;
    logic ss_edge;
    logic ss_fall;
    logic sel_active;

    logic [6:0] shift_q;
    logic [2:0] bit_cnt;

    assign sck_rise   = sck_sync[1] & ~sck_q;
    assign ss_edge    = (ss_io_sync[1] ^ ss_io_q) | (ss_data_sync[1] ^ ss_data_q);
    assign ss_fall    = (~ss_io_sync[1] & ss_io_q) | (~ss_data_sync[1] & ss_data_q);
    assign sel_active = ~ss_io_sync[1] | ~ss_data_sync[1];

    always_ff @(posedge clk_sys_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            sck_sync     <= '0;
            di_sync      <= '0;
            // Selects idle high
            ss_io_sync   <= '1;
            ss_data_sync <= '1;
            sck_q        <= 1'b0;
            ss_io_q      <= 1'b1;
            ss_data_q    <= 1'b1;
        end else begin
            sck_sync     <= {sck_sync[0], spi_sck_i};
            di_sync      <= {di_sync[0], spi_di_i};
            ss_io_sync   <= {ss_io_sync[0], spi_ss_io_n_i};
            ss_data_sync <= {ss_data_sync[0], spi_ss_data_n_i};
            sck_q        <= sck_sync[1];
            ss_io_q      <= ss_io_sync[1];
            ss_data_q    <= ss_data_sync[1];
        end
    end

    // MSB first byte assembly
    always_ff @(posedge clk_sys_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            shift_q       <= '0;
            bit_cnt       <= '0;
            byte_o        <= '0;
            byte_valid_o  <= 1'b0;
            data_chan_o   <= 1'b0;
            frame_start_o <= 1'b0;
            data_active_o <= 1'b0;
        end else begin
            byte_valid_o  <= 1'b0;
            frame_start_o <= ss_fall;
            data_active_o <= ~ss_data_sync[1];
            if (ss_edge) begin
                bit_cnt <= '0;
            end else if (sck_rise && sel_active) begin
                shift_q <= {shift_q[5:0], di_sync[1]};
                bit_cnt <= bit_cnt + 3'd1;
                if (bit_cnt == 3'd7) begin
                    byte_o       <= {shift_q, di_sync[1]};
                    byte_valid_o <= 1'b1;
                    data_chan_o  <= ~ss_data_sync[1];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== common/base_video_pkg.sv ====
`default_nettype none

package base_video_pkg;

    // Colour depth of the game and of the board DAC
    localparam int GAME_COLOR_W = 4;
    localparam int OUT_COLOR_W  = 6;

    // Pixel and line counter width
    localparam int POS_W = 10;

    typedef logic [GAME_COLOR_W-1:0] game_color_t;
    typedef logic [OUT_COLOR_W-1:0]  out_color_t;
    typedef logic [POS_W-1:0]        pos_t;

    // Pixel as produced by the game core
    typedef struct packed {
        game_color_t r;
        game_color_t g;
        game_color_t b;
        logic        hs;
        logic        vs;
    } game_pixel_t;

    // Pixel as driven to the board
    typedef struct packed {
        out_color_t r;
        out_color_t g;
        out_color_t b;
        logic       hsync;
        logic       vsync;
    } video_out_t;

    // OSD window, bounds included
    localparam pos_t OSD_X0 = 10'd16;
    localparam pos_t OSD_X1 = 10'd47;
    localparam pos_t OSD_Y0 = 10'd8;
    localparam pos_t OSD_Y1 = 10'd23;

endpackage

`default_nettype wire

// ==== common/base_cfg_pkg.sv ====
`default_nettype none

package base_cfg_pkg;

    // One byte as it arrives on the SPI link
    typedef logic [7:0] spi_byte_t;

    // Status and joystick words
    typedef logic [31:0] cfg_word_t;

    // ROM download address
    typedef logic [24:0] rom_addr_t;

    // Command codes on the IO select
    localparam spi_byte_t CMD_JOY0   = 8'h01;
    localparam spi_byte_t CMD_JOY1   = 8'h02;
    localparam spi_byte_t CMD_STATUS = 8'h1E;
    localparam spi_byte_t CMD_VIDEO  = 8'h04;

    // Data bytes after a word command, LSB first
    localparam int CFG_WORD_BYTES = 4;

    // Low two bits of the byte after CMD_VIDEO
    // Bit 0 enables the OSD, bit 1 selects composite sync
    typedef struct packed {
        logic csync_en;
        logic osd_en;
    } video_cfg_t;

    // Byte write towards the ROM loader
    typedef struct packed {
        rom_addr_t addr;
        spi_byte_t data;
        logic      wr;
    } rom_wr_t;

endpackage

`default_nettype wire
